// ==== sim.f ====
uart_rx_pkg.sv
rx_links.sv
baud_tick_gen.sv
rx_bit_sampler.sv
rx_frame_fsm.sv
rx_byte_fifo.sv
uart_rx_top.sv
tb_uart_rx.sv

// ==== run.sh ====
#!/bin/sh
# Build the UART receiver testbench with Verilator, run it, then look for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -f sim.f --top-module tb_uart_rx -o tb_uart_rx \
    && ./obj_dir/tb_uart_rx > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or run failed"; exit 1; }
cat sim.log
grep -q "All tests passed" sim.log \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed"; exit 1; }

// ==== tb_uart_rx.sv ====
// Testbench for the UART receiver, drives serial frames on rxd and checks every delivered byte
`timescale 1ns/1ns
`default_nettype none

module tb_uart_rx;

    // DUT defaults, one bit is 16 ticks of 4 clocks
    localparam int TICK_CLKS   = 4;
    localparam int BIT_CLKS    = 16 * TICK_CLKS;
    localparam int FRAME_BITS  = 11;
    localparam int FIFO_DEPTH  = 4;
    localparam int CREDIT_INIT = 2;
    // 40 frames of 11 bits at 4 ns per clock, plus margin
    localparam int WATCHDOG_NS = 40 * FRAME_BITS * BIT_CLKS * 4 + 20000;
    // Glitch starts near the middle of the bit
    localparam int GLITCH_OFF  = 28;

    logic       clk;
    logic       reset;
    logic       rxd;
    logic       credit_return = 1'b0;
    logic       rx_valid;
    logic [7:0] rx_data;
    logic       rx_frame_err;
    logic       rx_glitch;
    logic       rx_overrun;

    // Expected entries as {frame_err, glitch, data}
    logic [9:0] exp_q[$];
    integer     seed = 32'hc64;
    int         errors = 0;
    int         received = 0;
    int         overruns = 0;
    int         exp_overruns = 0;
    // Consumer side credit model
    int         avail = CREDIT_INIT;
    logic       ret_seen = 1'b0;
    logic       auto_return = 1'b1;
    int         returns_req = 0;
    int         returns_done = 0;

    uart_rx_top i_dut (
        .clk          (clk),
        .reset        (reset),
        .rxd          (rxd),
        .credit_return(credit_return),
        .rx_valid     (rx_valid),
        .rx_data      (rx_data),
        .rx_frame_err (rx_frame_err),
        .rx_glitch    (rx_glitch),
        .rx_overrun   (rx_overrun)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERR t=%0t %s got=%0h expected=%0h", $time, name, got, exp);
        end
    endtask

    // Expected entry from the data and the faults put on the line
    function automatic logic [9:0] expected_entry(input logic [7:0] data, input logic bad_stop,
                                                  input int glitch_bit, input int glitch_ticks);
        logic [7:0] d;
        logic       g;
        d = data;
        g = 1'b0;
        if (glitch_bit >= 0 && glitch_ticks > 0) begin
            // Any flip inside the sample window breaks stability
            g = 1'b1;
            // Four corrupted samples of seven would win the majority
            if (glitch_ticks >= 4) d = d ^ (8'd1 << glitch_bit);
        end
        return {bad_stop, g, d};
    endfunction

    // Start, 8 data bits LSB first, stop, one idle bit
    task automatic send_byte(input logic [7:0] data, input logic bad_stop, input int glitch_bit,
                             input int glitch_ticks, input logic expect_it);
        logic [10:0] frame;
        logic        level;
        frame = {1'b1, ~bad_stop, data, 1'b0};
        if (expect_it) exp_q.push_back(expected_entry(data, bad_stop, glitch_bit, glitch_ticks));
        for (int b = 0; b < FRAME_BITS; b++) begin
            for (int c = 0; c < BIT_CLKS; c++) begin
                level = frame[0];
                // Data bit n sits at frame position n+1
                if (b == glitch_bit + 1 && c >= GLITCH_OFF &&
                    c < GLITCH_OFF + glitch_ticks * TICK_CLKS) begin
                    level = ~level;
                end
                @(posedge clk);
                rxd <= level;
            end
            frame = frame >> 1;
        end
    endtask

    task automatic pulse_line_low(input int clks);
        repeat (clks) begin
            @(posedge clk);
            rxd <= 1'b0;
        end
        @(posedge clk);
        rxd <= 1'b1;
    endtask

    task automatic idle_bits(input int n);
        repeat (n * BIT_CLKS) @(posedge clk);
    endtask

    task automatic give_credits(input int n);
        @(posedge clk);
        returns_req <= returns_req + n;
    endtask

    // Waits until every expected byte is out, then a few cycles more
    task automatic wait_drain();
        while (exp_q.size() != 0) @(posedge clk);
        repeat (8) @(posedge clk);
    endtask

    // Consumer returns credits, either per delivery or on request
    always @(posedge clk) begin
        if (reset) begin
            credit_return <= 1'b0;
        end else if (auto_return && rx_valid) begin
            credit_return <= 1'b1;
        end else if (returns_done != returns_req) begin
            credit_return <= 1'b1;
            returns_done  <= returns_done + 1;
        end else begin
            credit_return <= 1'b0;
        end
    end

    // Monitor, compares each delivery with the queue head
    always @(posedge clk) begin
        logic [9:0] head;
        if (!reset) begin
            if (rx_valid) begin
                received++;
                // Credit used at the previous edge, returns counted one edge late
                if (avail == 0) begin
                    errors++;
                    $display("Byte delivered at %0t with no credit left", $time);
                end else begin
                    avail--;
                end
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Unexpected byte %0h delivered at %0t", rx_data, $time);
                end else begin
                    head = exp_q.pop_front();
                    check_value("rx_data", 32'(rx_data), 32'(head[7:0]));
                    check_value("rx_glitch", 32'(rx_glitch), 32'(head[8]));
                    check_value("rx_frame_err", 32'(rx_frame_err), 32'(head[9]));
                end
            end
            if (ret_seen) avail++;
            ret_seen = credit_return;
            if (rx_overrun) overruns++;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout, the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Run ended, errors=%0d delivered=%0d overruns=%0d", errors, received, overruns);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        logic [7:0] data;
        int         base;
        reset = 1'b1;
        rxd   = 1'b1;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        idle_bits(2);

        // Clean random bytes, a credit goes back after each
        for (int i = 0; i < 12; i++) begin
            data = 8'($random(seed));
            send_byte(data, 1'b0, -1, 0, 1'b1);
        end
        wait_drain();

        // Framing error, bit 7 low so the bad stop adds no falling edge
        data = 8'($random(seed)) & 8'h7f;
        send_byte(data, 1'b1, -1, 0, 1'b1);
        wait_drain();

        // 2-tick glitch inside data bit 3
        data = 8'($random(seed));
        send_byte(data, 1'b0, 3, 2, 1'b1);
        wait_drain();

        // False start of 3 ticks, then a real byte
        pulse_line_low(3 * TICK_CLKS);
        idle_bits(2);
        data = 8'($random(seed));
        send_byte(data, 1'b0, -1, 0, 1'b1);
        wait_drain();

        // Back-pressure, only CREDIT_INIT bytes may come out
        auto_return <= 1'b0;
        base = received;
        for (int i = 0; i < 4; i++) begin
            data = 8'($random(seed));
            send_byte(data, 1'b0, -1, 0, 1'b1);
        end
        idle_bits(2);
        check_value("delivered under back-pressure", 32'(received - base), 32'(CREDIT_INIT));
        // Two for the backlog, two to refill
        give_credits(4);
        wait_drain();

        // Overrun, the last byte finds the FIFO full
        base = received;
        for (int i = 0; i < CREDIT_INIT + FIFO_DEPTH + 1; i++) begin
            data = 8'($random(seed));
            send_byte(data, 1'b0, -1, 0, i < CREDIT_INIT + FIFO_DEPTH);
        end
        exp_overruns++;
        idle_bits(2);
        check_value("delivered before overrun drain", 32'(received - base), 32'(CREDIT_INIT));
        check_value("rx_overrun count", 32'(overruns), 32'(exp_overruns));
        give_credits(FIFO_DEPTH + CREDIT_INIT);
        wait_drain();
        idle_bits(1);

        check_value("rx_overrun count", 32'(overruns), 32'(exp_overruns));
        $display("Run ended, errors=%0d delivered=%0d overruns=%0d", errors, received, overruns);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== uart_rx_top.sv ====
// Top level of the UART receiver, wires tick, sampler, frame sequencer and FIFO together
`timescale 1ns/1ns
`default_nettype none

module uart_rx_top
    import uart_rx_pkg::*;
#(
    parameter int CLK_PER_TICK = 4,
    parameter int FIFO_DEPTH   = 4,
    parameter int CREDIT_INIT  = 2
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 rxd,
    input  logic                 credit_return,
    output logic                 rx_valid,
    output logic [DATA_BITS-1:0] rx_data,
    output logic                 rx_frame_err,
    output logic                 rx_glitch,
    output logic                 rx_overrun
);

    logic tick;
    logic rxd_sync;

    // Sampler to sequencer, sequencer to FIFO
    rx_bit_if  bit_link ();
    rx_byte_if byte_link ();

    // 16x oversampling tick
    baud_tick_gen #(
        .CLK_PER_TICK(CLK_PER_TICK)
    ) i_baud (
        .clk  (clk),
        .reset(reset),
        .tick (tick)
    );

    rx_bit_sampler i_sampler (
        .clk     (clk),
        .reset   (reset),
        .tick    (tick),
        .rxd_sync(rxd_sync),
        .link    (bit_link.sampler)
    );

    // Owns the line synchronizer
    rx_frame_fsm i_frame (
        .clk     (clk),
        .reset   (reset),
        .rxd     (rxd),
        .rxd_sync(rxd_sync),
        .bits    (bit_link.frame),
        .bytes   (byte_link.frame)
    );

    rx_byte_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .CREDIT_INIT(CREDIT_INIT)
    ) i_fifo (
        .clk          (clk),
        .reset        (reset),
        .credit_return(credit_return),
        .bytes        (byte_link.fifo),
        .rx_valid     (rx_valid),
        .rx_data      (rx_data),
        .rx_frame_err (rx_frame_err),
        .rx_glitch    (rx_glitch),
        .rx_overrun   (rx_overrun)
    );

endmodule

`default_nettype wire

// ==== rx_byte_fifo.sv ====
// Receive byte FIFO with overrun reporting and credit-gated delivery to the consumer
`timescale 1ns/1ns
`default_nettype none

module rx_byte_fifo
    import uart_rx_pkg::*;
#(
    parameter int FIFO_DEPTH  = 4,
    parameter int CREDIT_INIT = 2
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 credit_return,
    rx_byte_if.fifo              bytes,
    output logic                 rx_valid,
    output logic [DATA_BITS-1:0] rx_data,
    output logic                 rx_frame_err,
    output logic                 rx_glitch,
    output logic                 rx_overrun
);

    // Depth is a power of two, at least 2, so pointers wrap on their own
    localparam int AW = $clog2(FIFO_DEPTH);
    localparam int CW = $clog2(CREDIT_INIT + 2);
    localparam int EW = DATA_BITS + 2;

    // Entry is {frame_err, glitch, data}
    logic [EW-1:0] mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic [CW-1:0] credits;
    logic          full;
    logic          empty;
    logic          wr_en;
    logic          rd_en;

    assign full  = (count == (AW+1)'(FIFO_DEPTH));
    assign empty = (count == '0);
    assign wr_en = bytes.push & ~full;
    // Deliver only with a credit in hand
    assign rd_en = (credits != '0) & ~empty;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            credits    <= CW'(CREDIT_INIT);
            rx_valid   <= 1'b0;
            rx_overrun <= 1'b0;
        end else begin
            rx_valid   <= rd_en;
            rx_overrun <= bytes.push & full;
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;
            count <= count + (AW+1)'(wr_en) - (AW+1)'(rd_en);
            // Use and return in one cycle cancel out
            case ({rd_en, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: ;
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= {bytes.frame_err, bytes.glitch, bytes.data};
        end
    end

    // Output register, loaded only on a read
    always_ff @(posedge clk) begin
        if (rd_en) begin
            {rx_frame_err, rx_glitch, rx_data} <= mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

// ==== rx_frame_fsm.sv ====
// Synchronizes the serial line and sequences start, data and stop windows into byte pushes
`timescale 1ns/1ns
`default_nettype none

module rx_frame_fsm
    import uart_rx_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     rxd,
    output logic     rxd_sync,
    rx_bit_if.frame  bits,
    rx_byte_if.frame bytes
);

    localparam int CNT_W = $clog2(DATA_BITS);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(DATA_BITS - 1);

    frame_state_t state;

    // Line synchronizer and edge detect
    logic rxd_meta;
    logic rxd_prev;
    logic fall;
    logic edge_pend;
    logic start_req;

    // Sequencing
    logic             start_r;
    logic [CNT_W-1:0] bit_cnt;

    // Byte being assembled
    logic [DATA_BITS-1:0] shift_reg;
    logic                 glitch_acc;
    logic                 frame_err_r;

    // Two flops onto clk, line idles high
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    assign fall = rxd_prev & ~rxd_sync;

    // Stop window ends a little after the real stop bit, so a start
    // edge seen while still in FR_STOP is held until the line recovers
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            edge_pend <= 1'b0;
        end else if (state == FR_STOP && fall) begin
            edge_pend <= 1'b1;
        end else if (rxd_sync || state == FR_IDLE || state == FR_PUSH) begin
            edge_pend <= 1'b0;
        end
    end

    assign start_req = fall | edge_pend;

    // Frame sequencing
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= FR_IDLE;
            start_r <= 1'b0;
            bit_cnt <= '0;
        end else begin
            start_r <= 1'b0;
            case (state)
                // Push cycle already watches for the next start
                FR_IDLE, FR_PUSH: begin
                    if (start_req) begin
                        start_r <= 1'b1;
                        state   <= FR_START;
                    end else begin
                        state <= FR_IDLE;
                    end
                end
                FR_START: begin
                    if (bits.bit_done) begin
                        if (bits.bit_value) begin
                            // False start, line back high mid-window
                            state <= FR_IDLE;
                        end else begin
                            start_r <= 1'b1;
                            bit_cnt <= '0;
                            state   <= FR_DATA;
                        end
                    end
                end
                FR_DATA: begin
                    if (bits.bit_done) begin
                        start_r <= 1'b1;
                        if (bit_cnt == LAST_BIT) begin
                            state <= FR_STOP;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                FR_STOP: begin
                    if (bits.bit_done) begin
                        state <= FR_PUSH;
                    end
                end
                default: state <= FR_IDLE;
            endcase
        end
    end

    // Byte assembly, LSB arrives first
    always_ff @(posedge clk) begin
        if (bits.bit_done) begin
            case (state)
                FR_START: glitch_acc <= ~bits.bit_stable;
                FR_DATA: begin
                    shift_reg  <= {bits.bit_value, shift_reg[DATA_BITS-1:1]};
                    glitch_acc <= glitch_acc | ~bits.bit_stable;
                end
                FR_STOP: begin
                    frame_err_r <= ~bits.bit_value;
                    glitch_acc  <= glitch_acc | ~bits.bit_stable;
                end
                default: ;
            endcase
        end
    end

    assign bits.bit_start  = start_r;
    // One push per good frame, the cycle after the stop window
    assign bytes.push      = (state == FR_PUSH);
    assign bytes.data      = shift_reg;
    assign bytes.frame_err = frame_err_r;
    assign bytes.glitch    = glitch_acc;

endmodule

`default_nettype wire

// ==== rx_bit_sampler.sv ====
// Samples one bit window of the synchronized line, returns majority value and stability flag
`timescale 1ns/1ns
`default_nettype none

module rx_bit_sampler
    import uart_rx_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      tick,
    input  logic      rxd_sync,
    rx_bit_if.sampler link
);

    sampler_state_t state;

    // Ticks seen since the window opened
    logic [4:0] tick_cnt;
    logic [4:0] tick_next;

    // Sample accumulation
    logic [2:0] ones_cnt;
    logic       prev_sample;
    logic       stable_acc;

    // Result registers
    logic       done_r;
    logic       value_r;
    logic       stable_r;

    assign tick_next = tick_cnt + 5'd1;

    // Window sequencing
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= SMP_LOCK;
            tick_cnt <= '0;
            done_r   <= 1'b0;
        end else begin
            done_r <= 1'b0;
            case (state)
                SMP_LOCK: begin
                    // Also taken back to back with the previous bit_done
                    if (link.bit_start) begin
                        tick_cnt <= '0;
                        state    <= SMP_WAIT;
                    end
                end
                SMP_WAIT: begin
                    if (tick) begin
                        tick_cnt <= tick_next;
                        if (tick_next == SAMPLE_FIRST - 5'd1) begin
                            state <= SMP_TAKE;
                        end
                    end
                end
                SMP_TAKE: begin
                    if (tick) begin
                        tick_cnt <= tick_next;
                        if (tick_next == SAMPLE_LAST) begin
                            state <= SMP_HOLD;
                        end
                    end
                end
                SMP_HOLD: begin
                    // Window closes on the 16th tick
                    if (tick) begin
                        tick_cnt <= tick_next;
                        if (tick_next == OVERSAMPLE) begin
                            done_r <= 1'b1;
                            state  <= SMP_LOCK;
                        end
                    end
                end
                default: state <= SMP_LOCK;
            endcase
        end
    end

    // Sample path
    always_ff @(posedge clk) begin
        if (state == SMP_LOCK && link.bit_start) begin
            ones_cnt   <= '0;
            stable_acc <= 1'b1;
        end else if (state == SMP_TAKE && tick) begin
            ones_cnt    <= ones_cnt + {2'b00, rxd_sync};
            prev_sample <= rxd_sync;
            // First sample has nothing to compare against
            if (tick_next != SAMPLE_FIRST && rxd_sync != prev_sample) begin
                stable_acc <= 1'b0;
            end
        end else if (state == SMP_HOLD && tick && tick_next == OVERSAMPLE) begin
            value_r  <= (ones_cnt >= MAJORITY);
            stable_r <= stable_acc;
        end
    end

    // Results valid with bit_done
    assign link.bit_done   = done_r;
    assign link.bit_value  = value_r;
    assign link.bit_stable = stable_r;

endmodule

`default_nettype wire

// ==== baud_tick_gen.sv ====
// Free-running divider giving the 16x oversampling tick for the receive sampler
`timescale 1ns/1ns
`default_nettype none

module baud_tick_gen #(
    parameter int CLK_PER_TICK = 4
) (
    input  logic clk,
    input  logic reset,
    output logic tick
);

    // Counter must hold CLK_PER_TICK-1, at least one bit wide
    localparam int CNT_W = (CLK_PER_TICK > 1) ? $clog2(CLK_PER_TICK) : 1;
    localparam logic [CNT_W-1:0] RELOAD = CNT_W'(CLK_PER_TICK - 1);

    logic [CNT_W-1:0] count;

    // Down-count, pulse and reload at zero
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= RELOAD;
            tick  <= 1'b0;
        end else begin
            if (count == '0) begin
                count <= RELOAD;
                tick  <= 1'b1;
            end else begin
                count <= count - 1'b1;
                tick  <= 1'b0;
            end
        end
    end

    // One pulse every CLK_PER_TICK clocks

endmodule

`default_nettype wire

// ==== rx_links.sv ====
// Internal links of the receiver, sampler to frame sequencer and frame sequencer to FIFO
`timescale 1ns/1ns
`default_nettype none

// One bit window request and its result
interface rx_bit_if;
    logic bit_start;
    logic bit_done;
    logic bit_value;
    logic bit_stable;

    // Frame side opens windows and reads results
    modport frame (
        output bit_start,
        input  bit_done, bit_value, bit_stable
    );

    // Sampler side answers once per window
    modport sampler (
        input  bit_start,
        output bit_done, bit_value, bit_stable
    );
endinterface

// One received byte with its flags, a single push per frame
interface rx_byte_if
    import uart_rx_pkg::*;
();
    logic                 push;
    logic [DATA_BITS-1:0] data;
    logic                 frame_err;
    logic                 glitch;

    modport frame (output push, data, frame_err, glitch);

    // FIFO takes every push, full or not
    modport fifo (input push, data, frame_err, glitch);
endinterface

`default_nettype wire

// ==== uart_rx_pkg.sv ====
// Oversampling constants and state types shared by the UART receive blocks, imported per module
`default_nettype none

package uart_rx_pkg;

    // Ticks per bit window, counted in 5 bits
    localparam logic [4:0] OVERSAMPLE = 5'd16;

    // Window tick indexes of the first and last sample
    localparam logic [4:0] SAMPLE_FIRST = 5'd5;
    localparam logic [4:0] SAMPLE_LAST  = 5'd11;

    // Ones needed out of seven samples to call the bit a 1
    localparam logic [2:0] MAJORITY = 3'd4;

    // Payload bits per frame, no parity
    localparam int DATA_BITS = 8;

    // Bit sampler states
    typedef enum logic [1:0] {
        SMP_LOCK = 2'd0,    // idle until a window opens
        SMP_WAIT = 2'd1,    // ticks ahead of the first sample
        SMP_TAKE = 2'd2,    // sampling the middle of the window
        SMP_HOLD = 2'd3     // ticks after the last sample
    } sampler_state_t;

    // Frame sequencer states
    typedef enum logic [2:0] {
        FR_IDLE  = 3'd0,
        FR_START = 3'd1,
        FR_DATA  = 3'd2,
        FR_STOP  = 3'd3,
        FR_PUSH  = 3'd4
    } frame_state_t;

endpackage

`default_nettype wire
